// File: Makefile
# Verilator simulation of the UART matrix calculator

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_matcalc
FILELIST = sim.f
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: alu/matrix_alu.sv
// Matrix operation sequencer
`timescale 1ns/1ps

module matrix_alu (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  btn_confirm,
  input  logic [matcalc_pkg::OP_W-1:0]          sw_op,
  input  logic [7:0]                            sw_scalar,
  input  logic signed [matcalc_pkg::ELEM_W-1:0] a_el,
  input  logic signed [matcalc_pkg::ELEM_W-1:0] b_el,
  input  logic [matcalc_pkg::DIM_W-1:0]         a_rows,
  input  logic [matcalc_pkg::DIM_W-1:0]         a_cols,
  input  logic [matcalc_pkg::DIM_W-1:0]         b_rows,
  input  logic [matcalc_pkg::DIM_W-1:0]         b_cols,
  input  logic                                  a_valid,
  input  logic                                  b_valid,
  output logic [matcalc_pkg::DIM_W-1:0]         rd_row,
  output logic [matcalc_pkg::DIM_W-1:0]         rd_col,
  output logic                                  tx_start,
  output logic [7:0]                            tx_byte,
  input  logic                                  tx_busy,
  output logic                                  op_busy,
  output logic                                  op_err
);

  localparam int RW = matcalc_pkg::RES_W;

  // FSM states, ROWS to LO each send one byte
  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_CHECK = 3'd1;
  localparam logic [2:0] S_ROWS  = 3'd2;
  localparam logic [2:0] S_COLS  = 3'd3;
  localparam logic [2:0] S_HI    = 3'd4;
  localparam logic [2:0] S_LO    = 3'd5;
  localparam logic [2:0] S_DRAIN = 3'd6;

  logic [2:0]                            state;
  logic                                  btn_q;
  logic                                  confirm_edge;
  logic [matcalc_pkg::OP_W-1:0]          op_q;
  logic signed [matcalc_pkg::ELEM_W-1:0] scalar_q;
  logic [matcalc_pkg::DIM_W-1:0]         row_q;
  logic [matcalc_pkg::DIM_W-1:0]         col_q;
  logic [matcalc_pkg::DIM_W-1:0]         res_rows;
  logic [matcalc_pkg::DIM_W-1:0]         res_cols;
  logic                                  is_tp;
  logic                                  pair_op;
  logic                                  legal;
  logic                                  sending;
  logic                                  last_col;
  logic signed [RW-1:0]                  a_ext;
  logic signed [RW-1:0]                  b_ext;
  logic signed [RW-1:0]                  s_ext;
  logic signed [RW-1:0]                  res;

  assign confirm_edge = btn_confirm && !btn_q;

  // ================================================
  // Operand check and result shape
  // ================================================

  assign is_tp   = op_q == matcalc_pkg::OP_TRANSPOSE;
  assign pair_op = (op_q == matcalc_pkg::OP_ADD) || (op_q == matcalc_pkg::OP_SUB);
  // Add and sub need B with A's shape
  assign legal   = pair_op ?
                   (a_valid && b_valid && a_rows == b_rows && a_cols == b_cols) :
                   a_valid;

  // Transpose flips the shape and the read position
  assign res_rows = is_tp ? a_cols : a_rows;
  assign res_cols = is_tp ? a_rows : a_cols;
  assign rd_row   = is_tp ? col_q : row_q;
  assign rd_col   = is_tp ? row_q : col_q;
  assign last_col = col_q == res_cols - 1'b1;

  // ================================================
  // Element arithmetic
  // ================================================

  // Sign extension to result width
  assign a_ext = a_el;
  assign b_ext = b_el;
  assign s_ext = scalar_q;

  always_comb begin
    case (op_q)
      matcalc_pkg::OP_ADD:   res = a_ext + b_ext;
      matcalc_pkg::OP_SUB:   res = a_ext - b_ext;
      matcalc_pkg::OP_SCALE: res = a_ext * s_ext;
      default:               res = a_ext;
    endcase
  end

  // ================================================
  // Byte stream to the transmitter
  // ================================================

  assign sending  = state inside {S_ROWS, S_COLS, S_HI, S_LO};
  // Only offer a byte while the transmitter is free
  assign tx_start = sending && !tx_busy;

  always_comb begin
    case (state)
      S_ROWS:  tx_byte = {{(8 - matcalc_pkg::DIM_W){1'b0}}, res_rows};
      S_COLS:  tx_byte = {{(8 - matcalc_pkg::DIM_W){1'b0}}, res_cols};
      S_HI:    tx_byte = res[RW-1:8];
      default: tx_byte = res[7:0];
    endcase
  end

  assign op_busy = state != S_IDLE;
  // Single cycle, same cycle busy drops on a failed check
  assign op_err  = (state == S_CHECK) && !legal;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      btn_q <= 1'b0;
    end else begin
      btn_q <= btn_confirm;
      case (state)
        // Edges outside idle are ignored
        S_IDLE:  if (confirm_edge) state <= S_CHECK;
        S_CHECK: state <= legal ? S_ROWS : S_IDLE;
        S_ROWS:  if (tx_start) state <= S_COLS;
        S_COLS:  if (tx_start) state <= S_HI;
        S_HI:    if (tx_start) state <= S_LO;
        S_LO: begin
          if (tx_start) begin
            state <= (last_col && row_q == res_rows - 1'b1) ? S_DRAIN : S_HI;
          end
        end
        // Hold busy through the final stop bit
        S_DRAIN: if (!tx_busy) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Latched operation and result walk
  always_ff @(posedge clk) begin
    if (state == S_IDLE && confirm_edge) begin
      op_q     <= sw_op;
      scalar_q <= sw_scalar;
    end
    if (state == S_CHECK) begin
      row_q <= '0;
      col_q <= '0;
    end else if (state == S_LO && tx_start) begin
      if (last_col) begin
        col_q <= '0;
        row_q <= row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

endmodule

// File: common/matcalc_pkg.sv
// Matrix calculator shared constants
package matcalc_pkg;

  // ================================================
  // Serial link timing
  // ================================================

  // Clock cycles per UART bit
  localparam int CLKS_PER_BIT = 8;

  // ================================================
  // Element and matrix sizes
  // ================================================

  // Stored element, signed
  localparam int ELEM_W = 8;
  // Result element, goes out as two bytes
  localparam int RES_W = 16;
  // Row, column or dimension field
  localparam int DIM_W = 2;
  // Largest row or column count, dimensions encoded directly as 1 to 3
  localparam logic [DIM_W-1:0] MAX_DIM = 2'd3;
  // Operand slots A and B
  localparam int SLOT_CNT = 2;
  // Elements per slot
  localparam int ELEM_CNT = int'(MAX_DIM) * int'(MAX_DIM);
  // Flat element index
  localparam int IDX_W = 4;

  // ================================================
  // Operation codes
  // ================================================

  localparam int OP_W = 2;
  localparam logic [OP_W-1:0] OP_ADD       = 2'd0;
  localparam logic [OP_W-1:0] OP_SUB       = 2'd1;
  localparam logic [OP_W-1:0] OP_SCALE     = 2'd2;
  localparam logic [OP_W-1:0] OP_TRANSPOSE = 2'd3;

endpackage

// File: dv/matcalc_assert.sv
// Top-level output assertions
`timescale 1ns/1ps

module matcalc_assert (
  input logic clk,
  input logic rst,
  input logic uart_tx,
  input logic btn_confirm,
  input logic led_busy,
  input logic led_err
);

  // Failure count, read by the testbench at the end
  int fail_cnt = 0;

  // Serial line idles high outside an operation
  idle_line_high: assert property (@(posedge clk) disable iff (rst) !led_busy |-> uart_tx)
    else begin
      $error("uart_tx low while led_busy is low");
      fail_cnt++;
    end

  // LEDs cleared by reset
  reset_leds_low: assert property (@(posedge clk) rst |=> (!led_busy && !led_err))
    else begin
      $error("led_busy or led_err high during reset");
      fail_cnt++;
    end

  // Busy only follows a confirm edge one cycle earlier
  busy_needs_confirm: assert property (@(posedge clk) disable iff (rst)
    $rose(led_busy) |-> ($past(btn_confirm) && !$past(btn_confirm, 2)))
    else begin
      $error("led_busy rose without a confirm edge");
      fail_cnt++;
    end

endmodule

// File: dv/tb_matcalc.sv
// Matrix calculator testbench
`timescale 1ns/1ps

module tb_matcalc;

  localparam int CLK_NS   = 4;
  localparam int BIT_CLKS = matcalc_pkg::CLKS_PER_BIT;
  // Element fill choice
  localparam bit RND = 1'b0;
  localparam bit FIX = 1'b1;

  // One input frame, a bad header field ends it early
  typedef struct packed {
    logic [7:0] id;
    logic [7:0] rows;
    logic [7:0] cols;
    logic       fixed;
  } frame_t;

  logic                         clk;
  logic                         rst;
  logic                         uart_rx;
  logic                         uart_tx;
  logic                         btn_confirm;
  logic [matcalc_pkg::OP_W-1:0] sw_op;
  logic [7:0]                   sw_scalar;
  logic                         led_busy;
  logic                         led_err;

  // ================================================
  // Test table and reference model
  // ================================================

  string                        t_name [$];
  int                           t_nfr [$];
  frame_t                       t_fr0 [$];
  frame_t                       t_fr1 [$];
  logic [matcalc_pkg::OP_W-1:0] t_op [$];
  logic [7:0]                   t_scalar [$];
  logic                         t_err [$];

  // Slot contents as the host wrote them
  logic signed [7:0] m_el [matcalc_pkg::SLOT_CNT][matcalc_pkg::MAX_DIM][matcalc_pkg::MAX_DIM];
  int                m_rows [matcalc_pkg::SLOT_CNT];
  int                m_cols [matcalc_pkg::SLOT_CNT];
  bit                m_valid [matcalc_pkg::SLOT_CNT];

  logic [7:0] rx_q [$];
  logic [7:0] exp_q [$];
  int         errors;
  int         n_pass;
  int         n_fail;
  longint     wd_ns;

  matcalc_top DUT (
    .clk(clk), .rst(rst), .uart_rx(uart_rx), .uart_tx(uart_tx),
    .btn_confirm(btn_confirm), .sw_op(sw_op), .sw_scalar(sw_scalar),
    .led_busy(led_busy), .led_err(led_err)
  );

  bind matcalc_top matcalc_assert u_assert (
    .clk(clk), .rst(rst), .uart_tx(uart_tx), .btn_confirm(btn_confirm),
    .led_busy(led_busy), .led_err(led_err)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  function automatic frame_t make_frame(int id, int rows, int cols, bit fixed);
    frame_t f;
    f.id    = 8'(id);
    f.rows  = 8'(rows);
    f.cols  = 8'(cols);
    f.fixed = fixed;
    return f;
  endfunction

  task automatic add_test(string name, int nfr, frame_t f0, frame_t f1,
                          logic [1:0] op, logic [7:0] scalar, logic err);
    t_name.push_back(name);
    t_nfr.push_back(nfr);
    t_fr0.push_back(f0);
    t_fr1.push_back(f1);
    t_op.push_back(op);
    t_scalar.push_back(scalar);
    t_err.push_back(err);
  endtask

  // ================================================
  // Host side of the serial link
  // ================================================

  // Start bit, data LSB first, stop bit
  task automatic send_byte(logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int k = 0; k < 10; k++) begin
      uart_rx = bits[k];
      repeat (BIT_CLKS) @(posedge clk);
      #1;
    end
  endtask

  task automatic send_frame(string name, frame_t f);
    logic signed [7:0] v;
    int                slot;
    bit                bad;
    slot = int'(f.id[0]);
    bad  = 1'b1;
    send_byte(f.id);
    if (f.id < matcalc_pkg::SLOT_CNT) begin
      send_byte(f.rows);
      if (f.rows >= 1 && f.rows <= matcalc_pkg::MAX_DIM) begin
        send_byte(f.cols);
        if (f.cols >= 1 && f.cols <= matcalc_pkg::MAX_DIM) begin
          bad = 1'b0;
          for (int r = 0; r < int'(f.rows); r++) begin
            for (int c = 0; c < int'(f.cols); c++) begin
              // Fixed fill is all negative
              v = f.fixed ? 8'(-3 - 14 * (r * 3 + c)) : 8'($urandom);
              m_el[slot][r][c] = v;
              send_byte(v);
            end
          end
          m_rows[slot]  = int'(f.rows);
          m_cols[slot]  = int'(f.cols);
          m_valid[slot] = 1'b1;
        end
      end
    end
    if (bad) begin
      assert (led_err === 1'b1) else begin
        $display("Mismatch %s led_err after bad frame: expected 1 actual %b", name, led_err);
        errors++;
      end
    end
  endtask

  // Result bytes, sampled mid-bit on the falling clock edge
  always begin : uart_monitor
    logic [7:0] b;
    @(negedge uart_tx);
    repeat (BIT_CLKS / 2) @(negedge clk);
    assert (uart_tx === 1'b0) else begin
      $display("Start bit on uart_tx did not stay low");
      errors++;
    end
    for (int k = 0; k < 8; k++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[k] = uart_tx;
    end
    repeat (BIT_CLKS) @(negedge clk);
    assert (uart_tx === 1'b1) else begin
      $display("Stop bit on uart_tx was low");
      errors++;
    end
    rx_q.push_back(b);
  end

  // ================================================
  // Expected results and checks
  // ================================================

  task automatic build_expected(logic [1:0] op, logic [7:0] scalar);
    int          rr;
    int          rc;
    int          v;
    bit          legal;
    logic [15:0] w;
    exp_q.delete();
    if (op == matcalc_pkg::OP_ADD || op == matcalc_pkg::OP_SUB) begin
      legal = m_valid[0] && m_valid[1] && m_rows[0] == m_rows[1] && m_cols[0] == m_cols[1];
    end else begin
      legal = m_valid[0];
    end
    // Illegal operation sends nothing
    if (legal) begin
      rr = (op == matcalc_pkg::OP_TRANSPOSE) ? m_cols[0] : m_rows[0];
      rc = (op == matcalc_pkg::OP_TRANSPOSE) ? m_rows[0] : m_cols[0];
      exp_q.push_back(8'(rr));
      exp_q.push_back(8'(rc));
      for (int i = 0; i < rr; i++) begin
        for (int j = 0; j < rc; j++) begin
          case (op)
            matcalc_pkg::OP_ADD:   v = int'(m_el[0][i][j]) + int'(m_el[1][i][j]);
            matcalc_pkg::OP_SUB:   v = int'(m_el[0][i][j]) - int'(m_el[1][i][j]);
            matcalc_pkg::OP_SCALE: v = int'(m_el[0][i][j]) * int'($signed(scalar));
            default:               v = int'(m_el[0][j][i]);
          endcase
          // High byte first
          w = 16'(v);
          exp_q.push_back(w[15:8]);
          exp_q.push_back(w[7:0]);
        end
      end
    end
  endtask

  task automatic finish_test(string name, int errs_at_start);
    if (errors == errs_at_start) begin
      n_pass++;
      $display("PASS %s", name);
    end else begin
      n_fail++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic run_test(int idx);
    int errs_at_start;
    errs_at_start = errors;
    if (t_nfr[idx] > 0) send_frame(t_name[idx], t_fr0[idx]);
    if (t_nfr[idx] > 1) send_frame(t_name[idx], t_fr1[idx]);
    build_expected(t_op[idx], t_scalar[idx]);
    rx_q.delete();
    sw_op       = t_op[idx];
    sw_scalar   = t_scalar[idx];
    btn_confirm = 1'b1;
    @(posedge clk);
    #1;
    btn_confirm = 1'b0;
    assert (led_busy === 1'b1) else begin
      $display("Confirm press in %s did not raise led_busy", t_name[idx]);
      errors++;
    end
    // Busy drops after the last stop bit or right after a failed check
    while (led_busy === 1'b1) begin
      @(posedge clk);
      #1;
    end
    assert (led_err === t_err[idx]) else begin
      $display("Mismatch %s led_err: expected %b actual %b", t_name[idx], t_err[idx], led_err);
      errors++;
    end
    assert (rx_q.size() == exp_q.size()) else begin
      $display("Mismatch %s byte count: expected %0d actual %0d",
               t_name[idx], exp_q.size(), rx_q.size());
      errors++;
    end
    for (int k = 0; k < exp_q.size() && k < rx_q.size(); k++) begin
      assert (rx_q[k] === exp_q[k]) else begin
        $display("Mismatch %s byte %0d: expected %02h actual %02h",
                 t_name[idx], k, exp_q[k], rx_q[k]);
        errors++;
      end
    end
    finish_test(t_name[idx], errs_at_start);
  endtask

  // ================================================
  // Main sequence
  // ================================================

  initial begin
    frame_t none;
    int     errs_at_start;
    none        = '0;
    rst         = 1'b1;
    uart_rx     = 1'b1;
    btn_confirm = 1'b0;
    sw_op       = '0;
    sw_scalar   = '0;
    errors      = 0;
    n_pass      = 0;
    n_fail      = 0;
    void'($urandom(43));

    // Name, frame count, frames, op, scalar, led_err after the operation
    add_test("reset_empty", 0, none, none, matcalc_pkg::OP_ADD, 8'd0, 1'b1);
    add_test("add_3x3", 2, make_frame(0, 3, 3, RND), make_frame(1, 3, 3, RND),
             matcalc_pkg::OP_ADD, 8'd0, 1'b0);
    add_test("sub_3x3", 0, none, none, matcalc_pkg::OP_SUB, 8'd0, 1'b0);
    add_test("add_1x1", 2, make_frame(0, 1, 1, RND), make_frame(1, 1, 1, RND),
             matcalc_pkg::OP_ADD, 8'd0, 1'b0);
    add_test("sub_1x1", 0, none, none, matcalc_pkg::OP_SUB, 8'd0, 1'b0);
    add_test("scale_neg", 1, make_frame(0, 2, 3, FIX), none,
             matcalc_pkg::OP_SCALE, 8'hF9, 1'b0);
    add_test("transpose_2x3", 1, make_frame(0, 2, 3, RND), none,
             matcalc_pkg::OP_TRANSPOSE, 8'd0, 1'b0);
    add_test("add_mismatch", 2, make_frame(0, 2, 2, RND), make_frame(1, 3, 1, RND),
             matcalc_pkg::OP_ADD, 8'd0, 1'b1);
    add_test("err_cleared", 0, none, none, matcalc_pkg::OP_SCALE, 8'd3, 1'b0);
    add_test("bad_rows", 2, make_frame(0, 0, 2, RND), make_frame(0, 2, 2, FIX),
             matcalc_pkg::OP_SCALE, 8'd5, 1'b0);
    add_test("bad_id", 2, make_frame(2, 2, 2, RND), make_frame(1, 2, 2, RND),
             matcalc_pkg::OP_ADD, 8'd0, 1'b0);

    // Two frames and a 20 byte result per test, doubled for reset and gaps
    wd_ns = 2 * t_name.size() * (2 * (3 + matcalc_pkg::ELEM_CNT) + 20) * 10 * BIT_CLKS * CLK_NS;
    fork
      begin
        #(wd_ns);
        $display("Watchdog expired after %0d ns before the tests finished", wd_ns);
        $display("Some tests failed");
        $finish;
      end
    join_none

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    errs_at_start = errors;
    assert (uart_tx === 1'b1 && led_busy === 1'b0 && led_err === 1'b0) else begin
      $display("Mismatch reset_outputs uart_tx,led_busy,led_err: expected 100 actual %b%b%b",
               uart_tx, led_busy, led_err);
      errors++;
    end
    finish_test("reset_outputs", errs_at_start);

    foreach (t_name[i]) run_test(i);

    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
             n_pass, n_fail, DUT.u_assert.fail_cnt);
    if (n_fail == 0 && DUT.u_assert.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: hdl/matcalc_top.sv
// UART matrix calculator top
`timescale 1ns/1ps

module matcalc_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         uart_rx,
  output logic                         uart_tx,
  input  logic                         btn_confirm,
  input  logic [matcalc_pkg::OP_W-1:0] sw_op,
  input  logic [7:0]                   sw_scalar,
  output logic                         led_busy,
  output logic                         led_err
);

  // Receiver to parser
  logic       rx_valid;
  logic [7:0] rx_byte;

  // Parser to store
  logic                                  hdr_wr;
  logic                                  wr_slot;
  logic [matcalc_pkg::DIM_W-1:0]         wr_rows;
  logic [matcalc_pkg::DIM_W-1:0]         wr_cols;
  logic                                  el_wr;
  logic [matcalc_pkg::DIM_W-1:0]         wr_row;
  logic [matcalc_pkg::DIM_W-1:0]         wr_col;
  logic signed [matcalc_pkg::ELEM_W-1:0] wr_data;
  logic                                  el_last;
  logic                                  frame_err;

  // Store to ALU
  logic [matcalc_pkg::DIM_W-1:0]         rd_row;
  logic [matcalc_pkg::DIM_W-1:0]         rd_col;
  logic signed [matcalc_pkg::ELEM_W-1:0] a_el;
  logic signed [matcalc_pkg::ELEM_W-1:0] b_el;
  logic [matcalc_pkg::DIM_W-1:0]         a_rows;
  logic [matcalc_pkg::DIM_W-1:0]         a_cols;
  logic [matcalc_pkg::DIM_W-1:0]         b_rows;
  logic [matcalc_pkg::DIM_W-1:0]         b_cols;
  logic                                  a_valid;
  logic                                  b_valid;

  // ALU to transmitter, plus status
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       op_busy;
  logic       op_err;
  logic       busy_q;

  // ================================================
  // Datapath chain
  // ================================================

  uart_rx u_uart_rx (
    .clk(clk), .rst(rst), .rxd(uart_rx), .rx_valid(rx_valid), .rx_byte(rx_byte)
  );

  matrix_input u_input (
    .clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
    .hdr_wr(hdr_wr), .wr_slot(wr_slot), .wr_rows(wr_rows), .wr_cols(wr_cols),
    .el_wr(el_wr), .wr_row(wr_row), .wr_col(wr_col), .wr_data(wr_data),
    .el_last(el_last), .frame_err(frame_err)
  );

  matrix_store u_store (
    .clk(clk), .rst(rst), .hdr_wr(hdr_wr), .wr_slot(wr_slot),
    .wr_rows(wr_rows), .wr_cols(wr_cols), .el_wr(el_wr), .wr_row(wr_row),
    .wr_col(wr_col), .wr_data(wr_data), .el_last(el_last),
    .rd_row(rd_row), .rd_col(rd_col), .a_el(a_el), .b_el(b_el),
    .a_rows(a_rows), .a_cols(a_cols), .b_rows(b_rows), .b_cols(b_cols),
    .a_valid(a_valid), .b_valid(b_valid)
  );

  matrix_alu u_alu (
    .clk(clk), .rst(rst), .btn_confirm(btn_confirm), .sw_op(sw_op),
    .sw_scalar(sw_scalar), .a_el(a_el), .b_el(b_el),
    .a_rows(a_rows), .a_cols(a_cols), .b_rows(b_rows), .b_cols(b_cols),
    .a_valid(a_valid), .b_valid(b_valid), .rd_row(rd_row), .rd_col(rd_col),
    .tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy),
    .op_busy(op_busy), .op_err(op_err)
  );

  uart_tx u_uart_tx (
    .clk(clk), .rst(rst), .tx_start(tx_start), .tx_byte(tx_byte),
    .txd(uart_tx), .tx_busy(tx_busy)
  );

  // ================================================
  // Status LEDs
  // ================================================

  assign led_busy = op_busy;

  // Error latch, a new accepted confirm clears it
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      led_err <= 1'b0;
    end else begin
      busy_q <= op_busy;
      // Set wins over the clear in the same cycle
      if (frame_err || op_err) begin
        led_err <= 1'b1;
      end else if (op_busy && !busy_q) begin
        led_err <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/matrix_input.sv
// Matrix frame parser
`timescale 1ns/1ps

module matrix_input (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    rx_valid,
  input  logic [7:0]                              rx_byte,
  output logic                                    hdr_wr,
  output logic                                    wr_slot,
  output logic [matcalc_pkg::DIM_W-1:0]           wr_rows,
  output logic [matcalc_pkg::DIM_W-1:0]           wr_cols,
  output logic                                    el_wr,
  output logic [matcalc_pkg::DIM_W-1:0]           wr_row,
  output logic [matcalc_pkg::DIM_W-1:0]           wr_col,
  output logic signed [matcalc_pkg::ELEM_W-1:0]   wr_data,
  output logic                                    el_last,
  output logic                                    frame_err
);

  // Frame fields in arrival order
  localparam logic [1:0] S_ID   = 2'd0;
  localparam logic [1:0] S_ROWS = 2'd1;
  localparam logic [1:0] S_COLS = 2'd2;
  localparam logic [1:0] S_ELEM = 2'd3;

  logic [1:0]                    state;
  logic                          slot_q;
  logic [matcalc_pkg::DIM_W-1:0] rows_q;
  logic [matcalc_pkg::DIM_W-1:0] cols_q;
  logic [matcalc_pkg::DIM_W-1:0] row_q;
  logic [matcalc_pkg::DIM_W-1:0] col_q;
  logic                          id_ok;
  logic                          dim_ok;
  logic                          last_col;

  // ================================================
  // Header checks
  // ================================================

  // Id must name an existing slot
  assign id_ok  = rx_byte < 8'(matcalc_pkg::SLOT_CNT);
  // Dimension 1 to MAX_DIM
  assign dim_ok = (rx_byte != 8'd0) && (rx_byte <= 8'(matcalc_pkg::MAX_DIM));

  assign frame_err = rx_valid &&
                     (((state == S_ID) && !id_ok) ||
                      ((state == S_ROWS || state == S_COLS) && !dim_ok));

  // ================================================
  // Store write strobes
  // ================================================

  // Header write on a good column byte
  assign hdr_wr  = rx_valid && (state == S_COLS) && dim_ok;
  assign wr_slot = slot_q;
  assign wr_rows = rows_q;
  // Cols come straight from the byte during the header write
  assign wr_cols = rx_byte[matcalc_pkg::DIM_W-1:0];

  assign last_col = col_q == cols_q - 1'b1;
  assign el_wr    = rx_valid && (state == S_ELEM);
  assign wr_row   = row_q;
  assign wr_col   = col_q;
  assign wr_data  = rx_byte;
  // Last element marks the slot valid
  assign el_last  = last_col && (row_q == rows_q - 1'b1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_ID;
    end else if (rx_valid) begin
      case (state)
        S_ID:    if (id_ok) state <= S_ROWS;
        // A bad dimension makes the next byte a new id
        S_ROWS:  state <= dim_ok ? S_COLS : S_ID;
        S_COLS:  state <= dim_ok ? S_ELEM : S_ID;
        default: if (el_last) state <= S_ID;
      endcase
    end
  end

  // Header fields and row-major position
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (state)
        S_ID:   slot_q <= rx_byte[0];
        S_ROWS: rows_q <= rx_byte[matcalc_pkg::DIM_W-1:0];
        S_COLS: begin
          cols_q <= rx_byte[matcalc_pkg::DIM_W-1:0];
          row_q  <= '0;
          col_q  <= '0;
        end
        default: begin
          if (last_col) begin
            col_q <= '0;
            row_q <= row_q + 1'b1;
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

// File: hdl/matrix_store.sv
// Two-slot matrix store
`timescale 1ns/1ps

module matrix_store (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  hdr_wr,
  input  logic                                  wr_slot,
  input  logic [matcalc_pkg::DIM_W-1:0]         wr_rows,
  input  logic [matcalc_pkg::DIM_W-1:0]         wr_cols,
  input  logic                                  el_wr,
  input  logic [matcalc_pkg::DIM_W-1:0]         wr_row,
  input  logic [matcalc_pkg::DIM_W-1:0]         wr_col,
  input  logic signed [matcalc_pkg::ELEM_W-1:0] wr_data,
  input  logic                                  el_last,
  input  logic [matcalc_pkg::DIM_W-1:0]         rd_row,
  input  logic [matcalc_pkg::DIM_W-1:0]         rd_col,
  output logic signed [matcalc_pkg::ELEM_W-1:0] a_el,
  output logic signed [matcalc_pkg::ELEM_W-1:0] b_el,
  output logic [matcalc_pkg::DIM_W-1:0]         a_rows,
  output logic [matcalc_pkg::DIM_W-1:0]         a_cols,
  output logic [matcalc_pkg::DIM_W-1:0]         b_rows,
  output logic [matcalc_pkg::DIM_W-1:0]         b_cols,
  output logic                                  a_valid,
  output logic                                  b_valid
);

  localparam int IW = matcalc_pkg::IDX_W;

  // Element array, slot 0 is A and slot 1 is B
  logic signed [matcalc_pkg::ELEM_W-1:0]
    mem [matcalc_pkg::SLOT_CNT][matcalc_pkg::ELEM_CNT];
  logic [matcalc_pkg::DIM_W-1:0]    rows_q [matcalc_pkg::SLOT_CNT];
  logic [matcalc_pkg::DIM_W-1:0]    cols_q [matcalc_pkg::SLOT_CNT];
  logic [matcalc_pkg::SLOT_CNT-1:0] valid_q;
  logic [IW-1:0]                    wr_idx;
  logic [IW-1:0]                    rd_idx;

  // Flat row-major index on a MAX_DIM pitch
  assign wr_idx = IW'(wr_row) * IW'(matcalc_pkg::MAX_DIM) + IW'(wr_col);
  assign rd_idx = IW'(rd_row) * IW'(matcalc_pkg::MAX_DIM) + IW'(rd_col);

  always_ff @(posedge clk) begin
    if (el_wr) mem[wr_slot][wr_idx] <= wr_data;
    if (hdr_wr) begin
      rows_q[wr_slot] <= wr_rows;
      cols_q[wr_slot] <= wr_cols;
    end
  end

  // New header invalidates the slot until its last element lands
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (hdr_wr) begin
      valid_q[wr_slot] <= 1'b0;
    end else if (el_wr && el_last) begin
      valid_q[wr_slot] <= 1'b1;
    end
  end

  // Same position from both slots
  assign a_el    = mem[0][rd_idx];
  assign b_el    = mem[1][rd_idx];
  assign a_rows  = rows_q[0];
  assign a_cols  = cols_q[0];
  assign b_rows  = rows_q[1];
  assign b_cols  = cols_q[1];
  assign a_valid = valid_q[0];
  assign b_valid = valid_q[1];

endmodule

// File: sim.f
common/matcalc_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/matrix_input.sv
hdl/matrix_store.sv
alu/matrix_alu.sv
hdl/matcalc_top.sv
dv/matcalc_assert.sv
dv/tb_matcalc.sv

// File: uart/uart_rx.sv
// UART serial receiver
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  // Baud counter width and wrap points
  localparam int CW = $clog2(matcalc_pkg::CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_END  = CW'(matcalc_pkg::CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_END = CW'(matcalc_pkg::CLKS_PER_BIT / 2 - 1);

  // FSM states
  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic          rxd_m;
  logic          rxd_s;
  logic [1:0]    state;
  logic [CW-1:0] cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shreg;

  // Byte stays in the shift register until the next frame's data
  assign rx_byte = shreg;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_m <= 1'b1;
      rxd_s <= 1'b1;
    end else begin
      rxd_m <= rxd;
      rxd_s <= rxd_m;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          cnt <= '0;
          // Falling edge starts a frame
          if (!rxd_s) state <= S_START;
        end
        S_START: begin
          if (cnt == HALF_END) begin
            cnt     <= '0;
            bit_idx <= '0;
            // Still low at mid start bit, otherwise a glitch
            state   <= rxd_s ? S_IDLE : S_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (cnt == BIT_END) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= S_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (cnt == BIT_END) begin
            // Low stop bit drops the byte
            rx_valid <= rxd_s;
            state    <= S_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Mid-bit sampling, LSB arrives first
  always_ff @(posedge clk) begin
    if (state == S_DATA && cnt == BIT_END) shreg <= {rxd_s, shreg[7:1]};
  end

endmodule

// File: uart/uart_tx.sv
// UART serial transmitter
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       txd,
  output logic       tx_busy
);

  localparam int CW = $clog2(matcalc_pkg::CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_END = CW'(matcalc_pkg::CLKS_PER_BIT - 1);

  logic [CW-1:0] cnt;
  // 0 is the start bit, 9 the stop bit
  logic [3:0]    bit_idx;
  // Data bits with the stop bit above them
  logic [8:0]    shreg;

  always_ff @(posedge clk) begin
    if (rst) begin
      txd     <= 1'b1;
      tx_busy <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end else if (!tx_busy) begin
      // Start bit goes out together with busy
      if (tx_start) begin
        tx_busy <= 1'b1;
        txd     <= 1'b0;
        cnt     <= '0;
        bit_idx <= '0;
      end
    end else if (cnt == BIT_END) begin
      cnt <= '0;
      if (bit_idx == 4'd9) begin
        // Stop bit done, line stays high
        tx_busy <= 1'b0;
      end else begin
        txd     <= shreg[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Shift out LSB first, ones fill from the top
  always_ff @(posedge clk) begin
    if (!tx_busy && tx_start) begin
      shreg <= {1'b1, tx_byte};
    end else if (tx_busy && cnt == BIT_END && bit_idx != 4'd9) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule
